//--- Bender.yml
package:
  name: icache

sources:
  - files:
      - source/cache_geom_pkg.sv
      - source/l2_bus_pkg.sv
      - source/dual_port_memory.sv
      - source/icache_lookup.sv
      - source/refill_controller.sv
      - source/icache_top.sv
  - target: test
    files:
      - dv/icache_scoreboard.sv
      - dv/icache_chk.sv
      - dv/icache_tb.sv

//--- dv/icache_chk.sv
`default_nettype none

module icache_chk (
    input logic                 CLK,
    input logic                 arst_n,
    input logic                 stall,
    input logic                 pc_ready,
    input logic [31:0]          instr,
    input logic                 instr_valid,
    input l2_bus_pkg::l2_addr_t l2_req,
    input logic                 l2_req_valid,
    input logic                 l2_req_ready
);

    timeunit 1ns;
    timeprecision 1ps;

    int fail_count = 0;

    // Address channel holds until the transfer
    req_stable: assert property (@(posedge CLK) disable iff (!arst_n)
        l2_req_valid && !l2_req_ready |=> l2_req_valid && $stable(l2_req))
    else
    begin
        fail_count++;
        $error("l2_req changed or dropped before l2_req_ready");
    end

    stall_holds_valid: assert property (@(posedge CLK) disable iff (!arst_n)
        stall |=> $stable(instr_valid))
    else
    begin
        fail_count++;
        $error("instr_valid changed under stall");
    end

    stall_holds_instr: assert property (@(posedge CLK) disable iff (!arst_n)
        stall && instr_valid |=> $stable(instr))
    else
    begin
        fail_count++;
        $error("instr changed under stall");
    end

    stall_blocks_fetch: assert property (@(posedge CLK) disable iff (!arst_n)
        stall |-> !pc_ready)
    else
    begin
        fail_count++;
        $error("pc_ready high under stall");
    end

    reset_quiet: assert property (@(posedge CLK)
        !arst_n |-> !instr_valid && !l2_req_valid)
    else
    begin
        fail_count++;
        $error("instr_valid or l2_req_valid high during reset");
    end

endmodule

bind icache_top icache_chk icache_chk_inst (
    .CLK(CLK),
    .arst_n(arst_n),
    .stall(stall),
    .pc_ready(pc_ready),
    .instr(instr),
    .instr_valid(instr_valid),
    .l2_req(l2_req),
    .l2_req_valid(l2_req_valid),
    .l2_req_ready(l2_req_ready)
);

`default_nettype wire

//--- dv/icache_scoreboard.sv
`default_nettype none

module icache_scoreboard (
    input  logic                  CLK,
    input  logic                  arst_n,
    input  logic [31:0]           pc,
    input  logic                  pc_valid,
    input  logic                  pc_ready,
    input  logic                  stall,
    input  logic [31:0]           instr,
    input  logic                  instr_valid,
    input  l2_bus_pkg::l2_addr_t  l2_req,
    input  logic                  l2_req_valid,
    input  logic                  l2_req_ready,
    input  logic                  l2_rsp_valid,
    input  logic                  l2_rsp_ready,
    output int                    error_count,
    output int                    pending,
    output int                    instr_count,
    output int                    req_count
);

    timeunit 1ns;
    timeprecision 1ps;

    localparam int SETS  = 64;
    localparam int SET_W = 6;
    localparam int TAG_W = 32 - 4 - SET_W;

    // Two-way model where lru_way holds the way used last
    logic             way_valid [2][SETS];
    logic [TAG_W-1:0] way_tag   [2][SETS];
    logic             lru_way   [SETS];
    logic [31:0]      pc_q      [$];
    logic [27:0]      req_q     [$];
    logic             rsp_owed;

    function automatic logic [31:0] word_at(input logic [31:0] word_addr);
        return word_addr * 32'h9E37_79B1;
    endfunction

    ////////////////////////////////////////
    // Cache model updated at acceptance
    ////////////////////////////////////////

    task automatic model_fetch(input logic [31:0] fetch_pc);
        logic [SET_W-1:0] set_idx;
        logic [TAG_W-1:0] tag;
        int               way;
        set_idx = fetch_pc[4 +: SET_W];
        tag     = fetch_pc[31 -: TAG_W];
        if (way_valid[0][set_idx] && (way_tag[0][set_idx] == tag))
            way = 0;
        else if (way_valid[1][set_idx] && (way_tag[1][set_idx] == tag))
            way = 1;
        else
        begin
            // Empty way first
            if (!way_valid[0][set_idx])
                way = 0;
            else if (!way_valid[1][set_idx])
                way = 1;
            else
                way = lru_way[set_idx] ? 0 : 1;
            way_valid[way][set_idx] = 1'b1;
            way_tag[way][set_idx]   = tag;
            req_q.push_back(fetch_pc[31:4]);
        end
        lru_way[set_idx] = (way == 1);
        pc_q.push_back(fetch_pc);
    endtask

    task automatic check_req();
        logic [27:0] expected;
        req_count++;
        if (req_q.size() == 0)
        begin
            $display("Unexpected L2 request for block 0x%07h", l2_req.block_addr);
            error_count++;
        end
        else
        begin
            expected = req_q.pop_front();
            if (l2_req.block_addr !== expected)
            begin
                $display("Fail l2_req expected 0x%07h got 0x%07h", expected, l2_req.block_addr);
                error_count++;
            end
        end
    endtask

    task automatic check_instr();
        logic [31:0] exp_pc;
        logic [31:0] expected;
        if (pc_q.size() == 0)
        begin
            $display("Instruction 0x%08h came out with no fetch outstanding", instr);
            error_count++;
        end
        else
        begin
            exp_pc   = pc_q.pop_front();
            expected = word_at(exp_pc >> 2);
            instr_count++;
            if (instr !== expected)
            begin
                $display("Fail instr at pc 0x%08h expected 0x%08h got 0x%08h",
                         exp_pc, expected, instr);
                error_count++;
            end
            // With no fetch left every miss has reached L2
            if ((pc_q.size() == 0) && (req_q.size() != 0))
            begin
                $display("%0d expected L2 requests never appeared", req_q.size());
                error_count++;
                req_q.delete();
            end
        end
    endtask

    task automatic check_rsp_ready();
        if (l2_rsp_ready && !rsp_owed)
        begin
            $display("l2_rsp_ready went high with no block request outstanding");
            error_count++;
        end
        if (l2_rsp_valid && l2_rsp_ready)
            rsp_owed = 1'b0;
        if (l2_req_valid && l2_req_ready)
            rsp_owed = 1'b1;
    endtask

    initial
    begin
        error_count = 0;
        pending     = 0;
        instr_count = 0;
        req_count   = 0;
        rsp_owed    = 1'b0;
        for (int s = 0; s < SETS; s++)
        begin
            way_valid[0][s] = 1'b0;
            way_valid[1][s] = 1'b0;
            lru_way[s]      = 1'b0;
        end
    end

    always @(posedge CLK)
    begin
        if (arst_n)
        begin
            if (l2_req_valid && l2_req_ready)
                check_req();
            check_rsp_ready();
            if (instr_valid && !stall)
                check_instr();
            if (pc_valid && pc_ready)
                model_fetch(pc);
            pending = pc_q.size();
        end
    end

endmodule

`default_nettype wire

//--- dv/icache_tb.sv
`default_nettype none

module icache_tb;

    timeunit 1ns;
    timeprecision 1ps;

    localparam int RESET_CYCLES = 16;
    localparam int COLD_N       = 16;
    localparam int STREAM_N     = 64;
    localparam int ASSOC_N      = 40;
    localparam int STALL_N      = 64;
    localparam int BP_N         = 64;
    localparam int MIX_N        = 400;
    localparam int FETCH_TOTAL  = COLD_N + STREAM_N + ASSOC_N + STALL_N + BP_N + MIX_N;
    // Pipeline depth plus worst L2 delay plus refill overhead per fetch
    localparam int CYCLE_LIMIT  = FETCH_TOTAL * (3 + 8 + 6) + RESET_CYCLES;

    logic                  CLK;
    logic                  arst_n;
    logic [31:0]           pc;
    logic                  pc_valid;
    logic                  pc_ready;
    logic                  stall;
    logic [31:0]           instr;
    logic                  instr_valid;
    l2_bus_pkg::l2_addr_t  l2_req;
    logic                  l2_req_valid;
    logic                  l2_req_ready;
    l2_bus_pkg::l2_block_t l2_rsp;
    logic                  l2_rsp_valid;
    logic                  l2_rsp_ready;

    int          error_count;
    int          pending;
    int          instr_count;
    int          req_count;
    int          cycle_count;
    logic [31:0] stim_state = 32'd45172;
    logic [31:0] l2_state = ~32'd45172;
    logic        stall_on;
    logic        gap_on;
    logic        bp_on;
    logic [31:0] pc_list [$];

    icache_top icache_top_inst (
        .CLK(CLK), .arst_n(arst_n), .pc(pc), .pc_valid(pc_valid), .pc_ready(pc_ready),
        .stall(stall), .instr(instr), .instr_valid(instr_valid),
        .l2_req(l2_req), .l2_req_valid(l2_req_valid), .l2_req_ready(l2_req_ready),
        .l2_rsp(l2_rsp), .l2_rsp_valid(l2_rsp_valid), .l2_rsp_ready(l2_rsp_ready)
    );

    icache_scoreboard icache_scoreboard_inst (
        .CLK(CLK), .arst_n(arst_n), .pc(pc), .pc_valid(pc_valid), .pc_ready(pc_ready),
        .stall(stall), .instr(instr), .instr_valid(instr_valid),
        .l2_req(l2_req), .l2_req_valid(l2_req_valid), .l2_req_ready(l2_req_ready),
        .l2_rsp_valid(l2_rsp_valid), .l2_rsp_ready(l2_rsp_ready),
        .error_count(error_count), .pending(pending),
        .instr_count(instr_count), .req_count(req_count)
    );

    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        return y ^ (y << 5);
    endfunction

    function automatic logic [31:0] stim_rand();
        stim_state = xorshift32(stim_state);
        return stim_state;
    endfunction

    function automatic logic [31:0] l2_rand();
        l2_state = xorshift32(l2_state);
        return l2_state;
    endfunction

    function automatic logic [31:0] word_at(input logic [31:0] word_addr);
        return word_addr * 32'h9E37_79B1;
    endfunction

    function automatic int total_errors();
        return error_count + icache_top_inst.icache_chk_inst.fail_count;
    endfunction

    initial
    begin
        CLK = 1'b0;
        forever
            #5 CLK = ~CLK;
    end

    initial
    begin : watchdog
        cycle_count = 0;
        while (cycle_count < CYCLE_LIMIT)
        begin
            @(posedge CLK);
            cycle_count++;
        end
        $display("Run stopped at the cycle limit of %0d with %0d fetches outstanding",
                 CYCLE_LIMIT, pending);
        $display("Errors found");
        $finish;
    end

    ////////////////////////////////////////
    // L2 responder
    ////////////////////////////////////////

    initial
    begin : l2_responder
        logic [27:0] block_addr;
        int          delay;
        l2_req_ready = 1'b0;
        l2_rsp_valid = 1'b0;
        l2_rsp       = '0;
        forever
        begin
            @(negedge CLK);
            l2_req_ready = bp_on ? (l2_rand() % 2 == 0) : 1'b1;
            @(posedge CLK);
            if (l2_req_valid && l2_req_ready)
            begin
                block_addr = l2_req.block_addr;
                delay      = 1 + int'(l2_rand() % 8);
                repeat (delay)
                    @(negedge CLK);
                l2_req_ready = 1'b0;
                // Lowest word in the low bits
                for (int i = 0; i < 4; i++)
                    l2_rsp.words[i] = word_at({2'b00, block_addr, 2'(i)});
                l2_rsp_valid = 1'b1;
                @(posedge CLK);
                while (!l2_rsp_ready)
                    @(posedge CLK);
                @(negedge CLK);
                l2_rsp_valid = 1'b0;
            end
        end
    end

    ////////////////////////////////////////
    // Fetch stimulus
    ////////////////////////////////////////

    task automatic build_cold();
        for (int i = 0; i < COLD_N; i++)
            pc_list.push_back(32'h0000_1000 + 32'(i) * 16 + (stim_rand() % 4) * 4);
    endtask

    task automatic build_stream();
        for (int i = 0; i < STREAM_N; i++)
            pc_list.push_back(32'h0000_1000 + 32'(i) * 4);
    endtask

    task automatic build_assoc();
        logic [21:0] tags [3];
        tags = '{22'h011, 22'h023, 22'h035};
        for (int i = 0; i < 24; i++)
            pc_list.push_back({tags[stim_rand() % 3], 6'd5, 2'(stim_rand() % 4), 2'b00});
        // Two tags taking turns in set 9
        for (int i = 0; i < ASSOC_N - 24; i++)
            pc_list.push_back({(i % 2 == 0) ? 22'h041 : 22'h052, 6'd9, 4'h0});
    endtask

    // 192 blocks over 64 sets force evictions
    task automatic build_random(input int count);
        for (int i = 0; i < count; i++)
            pc_list.push_back(32'h0002_0000 + (stim_rand() % 768) * 4);
    endtask

    task automatic drive_fetches();
        int idx;
        idx = 0;
        while (idx < pc_list.size())
        begin
            @(negedge CLK);
            pc       = pc_list[idx];
            pc_valid = !(gap_on && (stim_rand() % 8 == 0));
            stall    = stall_on && (stim_rand() % 4 == 0);
            @(posedge CLK);
            if (pc_valid && pc_ready)
                idx++;
        end
        @(negedge CLK);
        pc_valid = 1'b0;
        while (pending != 0)
        begin
            stall = stall_on && (stim_rand() % 4 == 0);
            @(negedge CLK);
        end
        stall = 1'b0;
        pc_list.delete();
    endtask

    task automatic run_test(input int num, input string name);
        int err_start;
        int instr_start;
        int req_start;
        err_start   = total_errors();
        instr_start = instr_count;
        req_start   = req_count;
        drive_fetches();
        $display("Test %0d %s done, %0d instructions, %0d l2 requests, %0d errors",
                 num, name, instr_count - instr_start, req_count - req_start,
                 total_errors() - err_start);
    endtask

    initial
    begin : main
        arst_n   = 1'b0;
        pc       = '0;
        pc_valid = 1'b0;
        stall    = 1'b0;
        stall_on = 1'b0;
        gap_on   = 1'b0;
        bp_on    = 1'b0;
        repeat (RESET_CYCLES)
            @(posedge CLK);
        @(negedge CLK);
        arst_n = 1'b1;

        build_cold();
        run_test(1, "cold misses");
        build_stream();
        run_test(2, "streaming hits");
        build_assoc();
        run_test(3, "associativity and LRU");

        stall_on = 1'b1;
        gap_on   = 1'b1;
        build_random(STALL_N);
        run_test(4, "stall");

        stall_on = 1'b0;
        gap_on   = 1'b0;
        bp_on    = 1'b1;
        build_random(BP_N);
        run_test(5, "L2 back-pressure");

        stall_on = 1'b1;
        gap_on   = 1'b1;
        build_random(MIX_N);
        run_test(6, "random mix");

        $display("Summary 6 tests, %0d instructions, %0d l2 requests, %0d errors",
                 instr_count, req_count, total_errors());
        if (total_errors() == 0)
            $display("No errors");
        else
            $display("Errors found");
        $finish;
    end

endmodule

`default_nettype wire

//--- flist.f
source/cache_geom_pkg.sv
source/l2_bus_pkg.sv
source/dual_port_memory.sv
source/icache_lookup.sv
source/refill_controller.sv
source/icache_top.sv
dv/icache_scoreboard.sv
dv/icache_chk.sv
dv/icache_tb.sv

//--- source/cache_geom_pkg.sv
`default_nettype none

package cache_geom_pkg;

    // Fetch address and instruction
    localparam int ADDR_W = 32;
    localparam int WORD_W = 32;

    // Block geometry
    localparam int WORDS_PER_BLOCK = 4;
    localparam int BLOCK_W = WORD_W * WORDS_PER_BLOCK;
    localparam int OFFSET_W = $clog2(BLOCK_W / 8);

    // Default set count, tag width follows from it
    localparam int LINE_COUNT_DEF = 64;
    localparam int TAG_W = ADDR_W - OFFSET_W - $clog2(LINE_COUNT_DEF);

    typedef struct packed {
        logic              valid;
        logic [ADDR_W-1:0] pc;
    } fetch_t;

    typedef struct packed {
        logic             valid;
        logic [TAG_W-1:0] tag;
    } tag_entry_t;

    typedef enum logic [2:0] {
        IDLE,
        SEND_ADDR,
        WAIT_DATA,
        WRITE_WAY,
        REPLAY
    } refill_state_e;

endpackage

`default_nettype wire

//--- source/dual_port_memory.sv
`default_nettype none

module dual_port_memory #(
    parameter int WIDTH      = 32,
    parameter int LINE_COUNT = 64
) (
    input  logic                          CLK,
    input  logic [$clog2(LINE_COUNT)-1:0] write_addr,
    input  logic [WIDTH-1:0]              write_data,
    input  logic                          write_en,
    input  logic [$clog2(LINE_COUNT)-1:0] read_addr,
    input  logic                          read_en,
    output logic [WIDTH-1:0]              read_data
);

    logic [WIDTH-1:0] mem [LINE_COUNT];

    always_ff @(posedge CLK)
    begin
        if (write_en)
            mem[write_addr] <= write_data;
    end

    // Output holds while read_en is low
    always_ff @(posedge CLK)
    begin
        if (read_en)
            read_data <= mem[read_addr];
    end

endmodule

`default_nettype wire

//--- source/icache_lookup.sv
`default_nettype none

module icache_lookup #(
    parameter int LINE_COUNT = 64,
    parameter type tag_entry_t = cache_geom_pkg::tag_entry_t
) (
    input  logic                              CLK,
    input  logic                              arst_n,
    input  logic [cache_geom_pkg::ADDR_W-1:0] pc,
    input  logic                              pc_valid,
    input  logic                              stall,
    output logic                              pc_ready,
    output logic [cache_geom_pkg::WORD_W-1:0] instr,
    output logic                              instr_valid,
    output logic [$clog2(LINE_COUNT)-1:0]     rd_set,
    output logic                              rd_en,
    input  tag_entry_t                        tag0,
    input  tag_entry_t                        tag1,
    input  l2_bus_pkg::l2_block_t             blk0,
    input  l2_bus_pkg::l2_block_t             blk1,
    input  logic [LINE_COUNT-1:0]             valid0,
    input  logic [LINE_COUNT-1:0]             valid1,
    output logic                              miss,
    output cache_geom_pkg::fetch_t            miss_fetch,
    output logic [$clog2(LINE_COUNT)-1:0]     hit_set,
    output logic                              hit_way,
    output logic                              hit_en,
    input  logic                              refill_done
);

    localparam int SET_W = $clog2(LINE_COUNT);
    localparam int TAG_W = $bits(tag_entry_t) - 1;
    localparam int OFFSET_W = cache_geom_pkg::OFFSET_W;

    typedef enum logic [1:0] {
        RUN,
        HOLD,
        REREAD
    } mode_e;

    mode_e                  mode_q;
    cache_geom_pkg::fetch_t if1_q;
    cache_geom_pkg::fetch_t if2_q;
    cache_geom_pkg::fetch_t if3_q;
    l2_bus_pkg::l2_block_t  blk3_q;
    logic [TAG_W-1:0]       tag2;
    logic                   hit0;
    logic                   hit1;
    logic                   advance;

    ////////////////////////////////////////
    // IF2 tag compare
    ////////////////////////////////////////

    assign tag2    = if2_q.pc[cache_geom_pkg::ADDR_W-1 -: TAG_W];
    assign hit_set = if2_q.pc[OFFSET_W +: SET_W];
    assign hit0    = valid0[hit_set] && tag0.valid && (tag0.tag == tag2);
    assign hit1    = valid1[hit_set] && tag1.valid && (tag1.tag == tag2);

    assign miss       = if2_q.valid && !(hit0 || hit1) && (mode_q == RUN) && !stall;
    assign miss_fetch = if2_q;
    assign advance    = (mode_q == RUN) && !stall && !miss;
    assign pc_ready   = advance;

    assign hit_en  = if2_q.valid && advance;
    assign hit_way = hit1;

    // Replay reads the IF2 set first, normal flow reads the IF1 set
    assign rd_set = (mode_q == RUN) ? if1_q.pc[OFFSET_W +: SET_W] : hit_set;
    assign rd_en  = advance
                 || (!stall && ((mode_q == REREAD) || ((mode_q == HOLD) && refill_done)));

    always_ff @(posedge CLK or negedge arst_n)
    begin
        if (!arst_n)
        begin
            mode_q      <= RUN;
            if1_q       <= '0;
            if2_q       <= '0;
            if3_q       <= '0;
            instr_valid <= 1'b0;
        end
        else
        begin
            case (mode_q)
                RUN:
                    if (miss)
                        mode_q <= HOLD;
                HOLD:
                    if (refill_done)
                        mode_q <= stall ? REREAD : RUN;
                default:
                    if (!stall)
                        mode_q <= RUN;
            endcase

            if (advance)
            begin
                if1_q.valid <= pc_valid;
                if1_q.pc    <= pc;
                if2_q       <= if1_q;
                if3_q       <= if2_q;
            end
            else if (!stall)
                if3_q.valid <= 1'b0;

            if (!stall)
                instr_valid <= if3_q.valid;
        end
    end

    ////////////////////////////////////////
    // Way and word select
    ////////////////////////////////////////

    always_ff @(posedge CLK)
    begin
        if (advance)
            blk3_q <= hit1 ? blk1 : blk0;
        if (!stall)
            instr <= blk3_q.words[if3_q.pc[OFFSET_W-1:2]];
    end

endmodule

`default_nettype wire

//--- source/icache_top.sv
`default_nettype none

module icache_top #(
    parameter int LINE_COUNT = cache_geom_pkg::LINE_COUNT_DEF,
    parameter type tag_entry_t = cache_geom_pkg::tag_entry_t
) (
    input  logic                              CLK,
    input  logic                              arst_n,
    input  logic [cache_geom_pkg::ADDR_W-1:0] pc,
    input  logic                              pc_valid,
    output logic                              pc_ready,
    input  logic                              stall,
    output logic [cache_geom_pkg::WORD_W-1:0] instr,
    output logic                              instr_valid,
    output l2_bus_pkg::l2_addr_t              l2_req,
    output logic                              l2_req_valid,
    input  logic                              l2_req_ready,
    input  l2_bus_pkg::l2_block_t             l2_rsp,
    input  logic                              l2_rsp_valid,
    output logic                              l2_rsp_ready
);

    localparam int SET_W = $clog2(LINE_COUNT);

    logic [SET_W-1:0]       rd_set;
    logic                   rd_en;
    tag_entry_t             tag0;
    tag_entry_t             tag1;
    l2_bus_pkg::l2_block_t  blk0;
    l2_bus_pkg::l2_block_t  blk1;
    logic [LINE_COUNT-1:0]  valid0;
    logic [LINE_COUNT-1:0]  valid1;
    logic                   miss;
    cache_geom_pkg::fetch_t miss_fetch;
    logic [SET_W-1:0]       hit_set;
    logic                   hit_way;
    logic                   hit_en;
    logic                   refill_done;
    logic [SET_W-1:0]       wr_set;
    tag_entry_t             wr_tag;
    l2_bus_pkg::l2_block_t  wr_blk;
    logic                   wr_en0;
    logic                   wr_en1;

    ////////////////////////////////////////
    // Tag and data banks, one per way
    ////////////////////////////////////////

    dual_port_memory #(.WIDTH($bits(tag_entry_t)), .LINE_COUNT(LINE_COUNT)) tag_ram_0 (
        .CLK(CLK), .write_addr(wr_set), .write_data(wr_tag), .write_en(wr_en0),
        .read_addr(rd_set), .read_en(rd_en), .read_data(tag0)
    );

    dual_port_memory #(.WIDTH($bits(tag_entry_t)), .LINE_COUNT(LINE_COUNT)) tag_ram_1 (
        .CLK(CLK), .write_addr(wr_set), .write_data(wr_tag), .write_en(wr_en1),
        .read_addr(rd_set), .read_en(rd_en), .read_data(tag1)
    );

    dual_port_memory #(.WIDTH(cache_geom_pkg::BLOCK_W), .LINE_COUNT(LINE_COUNT)) data_ram_0 (
        .CLK(CLK), .write_addr(wr_set), .write_data(wr_blk), .write_en(wr_en0),
        .read_addr(rd_set), .read_en(rd_en), .read_data(blk0)
    );

    dual_port_memory #(.WIDTH(cache_geom_pkg::BLOCK_W), .LINE_COUNT(LINE_COUNT)) data_ram_1 (
        .CLK(CLK), .write_addr(wr_set), .write_data(wr_blk), .write_en(wr_en1),
        .read_addr(rd_set), .read_en(rd_en), .read_data(blk1)
    );

    icache_lookup #(.LINE_COUNT(LINE_COUNT), .tag_entry_t(tag_entry_t)) icache_lookup_inst (
        .CLK(CLK), .arst_n(arst_n), .pc(pc), .pc_valid(pc_valid), .stall(stall),
        .pc_ready(pc_ready), .instr(instr), .instr_valid(instr_valid),
        .rd_set(rd_set), .rd_en(rd_en), .tag0(tag0), .tag1(tag1), .blk0(blk0), .blk1(blk1),
        .valid0(valid0), .valid1(valid1), .miss(miss), .miss_fetch(miss_fetch),
        .hit_set(hit_set), .hit_way(hit_way), .hit_en(hit_en), .refill_done(refill_done)
    );

    refill_controller #(.LINE_COUNT(LINE_COUNT), .tag_entry_t(tag_entry_t)) refill_controller_inst (
        .CLK(CLK), .arst_n(arst_n), .miss(miss), .miss_fetch(miss_fetch),
        .hit_set(hit_set), .hit_way(hit_way), .hit_en(hit_en), .refill_done(refill_done),
        .valid0(valid0), .valid1(valid1), .wr_set(wr_set), .wr_tag(wr_tag),
        .wr_blk(wr_blk), .wr_en0(wr_en0), .wr_en1(wr_en1),
        .l2_req(l2_req), .l2_req_valid(l2_req_valid), .l2_req_ready(l2_req_ready),
        .l2_rsp(l2_rsp), .l2_rsp_valid(l2_rsp_valid), .l2_rsp_ready(l2_rsp_ready)
    );

endmodule

`default_nettype wire

//--- source/l2_bus_pkg.sv
`default_nettype none

package l2_bus_pkg;

    localparam int BLOCK_ADDR_W = cache_geom_pkg::ADDR_W - cache_geom_pkg::OFFSET_W;

    // L1 to L2, block address only
    typedef struct packed {
        logic [BLOCK_ADDR_W-1:0] block_addr;
    } l2_addr_t;

    // L2 to L1, word 0 sits in the low bits
    typedef struct packed {
        logic [cache_geom_pkg::WORDS_PER_BLOCK-1:0][cache_geom_pkg::WORD_W-1:0] words;
    } l2_block_t;

endpackage

`default_nettype wire

//--- source/refill_controller.sv
`default_nettype none

module refill_controller #(
    parameter int LINE_COUNT = 64,
    parameter type tag_entry_t = cache_geom_pkg::tag_entry_t
) (
    input  logic                          CLK,
    input  logic                          arst_n,
    input  logic                          miss,
    input  cache_geom_pkg::fetch_t        miss_fetch,
    input  logic [$clog2(LINE_COUNT)-1:0] hit_set,
    input  logic                          hit_way,
    input  logic                          hit_en,
    output logic                          refill_done,
    output logic [LINE_COUNT-1:0]         valid0,
    output logic [LINE_COUNT-1:0]         valid1,
    output logic [$clog2(LINE_COUNT)-1:0] wr_set,
    output tag_entry_t                    wr_tag,
    output l2_bus_pkg::l2_block_t         wr_blk,
    output logic                          wr_en0,
    output logic                          wr_en1,
    output l2_bus_pkg::l2_addr_t          l2_req,
    output logic                          l2_req_valid,
    input  logic                          l2_req_ready,
    input  l2_bus_pkg::l2_block_t         l2_rsp,
    input  logic                          l2_rsp_valid,
    output logic                          l2_rsp_ready
);

    localparam int SET_W = $clog2(LINE_COUNT);
    localparam int TAG_W = $bits(tag_entry_t) - 1;

    cache_geom_pkg::refill_state_e state_q;
    cache_geom_pkg::refill_state_e state_d;
    logic [LINE_COUNT-1:0]         lru_q;
    logic                          victim;

    // Set and tag come straight from the pending block address
    assign wr_set = l2_req.block_addr[SET_W-1:0];

    always_comb
    begin
        wr_tag       = '0;
        wr_tag.valid = 1'b1;
        wr_tag.tag   = l2_req.block_addr[SET_W +: TAG_W];
    end

    // Empty way first, else the way not used last
    always_comb
    begin
        if (!valid0[wr_set])
            victim = 1'b0;
        else if (!valid1[wr_set])
            victim = 1'b1;
        else
            victim = !lru_q[wr_set];
    end

    always_comb
    begin
        state_d = state_q;
        case (state_q)
            cache_geom_pkg::IDLE:
                if (miss && miss_fetch.valid)
                    state_d = cache_geom_pkg::SEND_ADDR;
            cache_geom_pkg::SEND_ADDR:
                if (l2_req_ready)
                    state_d = cache_geom_pkg::WAIT_DATA;
            cache_geom_pkg::WAIT_DATA:
                if (l2_rsp_valid)
                    state_d = cache_geom_pkg::WRITE_WAY;
            cache_geom_pkg::WRITE_WAY:
                state_d = cache_geom_pkg::REPLAY;
            default:
                state_d = cache_geom_pkg::IDLE;
        endcase
    end

    assign l2_req_valid = (state_q == cache_geom_pkg::SEND_ADDR);
    assign l2_rsp_ready = (state_q == cache_geom_pkg::WAIT_DATA);
    assign wr_en0       = (state_q == cache_geom_pkg::WRITE_WAY) && !victim;
    assign wr_en1       = (state_q == cache_geom_pkg::WRITE_WAY) && victim;
    assign refill_done  = (state_q == cache_geom_pkg::REPLAY);

    always_ff @(posedge CLK or negedge arst_n)
    begin
        if (!arst_n)
        begin
            state_q <= cache_geom_pkg::IDLE;
            valid0  <= '0;
            valid1  <= '0;
            lru_q   <= '0;
        end
        else
        begin
            state_q <= state_d;
            if (state_q == cache_geom_pkg::WRITE_WAY)
            begin
                if (victim)
                    valid1[wr_set] <= 1'b1;
                else
                    valid0[wr_set] <= 1'b1;
                lru_q[wr_set] <= victim;
            end
            else if (hit_en)
                lru_q[hit_set] <= hit_way;
        end
    end

    always_ff @(posedge CLK)
    begin
        if ((state_q == cache_geom_pkg::IDLE) && miss && miss_fetch.valid)
            l2_req.block_addr <= miss_fetch.pc[cache_geom_pkg::ADDR_W-1:cache_geom_pkg::OFFSET_W];
        if (l2_rsp_valid && l2_rsp_ready)
            wr_blk <= l2_rsp;
    end

endmodule

`default_nettype wire
